// File: design/eth_dma_pkg.sv
`default_nettype none

package eth_dma_pkg;

  // Bus and field widths
  localparam int BD_WORD_W   = 32;
  localparam int BD_IDX_W    = 7;
  localparam int BD_ADDR_W   = BD_IDX_W + 1;
  localparam int BUF_ADDR_W  = 11;
  localparam int AXI_ADDR_W  = 32;
  localparam int AXI_DATA_W  = 32;
  localparam int AXI_LEN_W   = 8;
  localparam int FRAME_LEN_W = 16;
  localparam int TX_NBYTES_W = 11;

  typedef logic [BD_WORD_W-1:0]   bd_word_t;
  typedef logic [BD_IDX_W-1:0]    bd_idx_t;
  // Word 2n holds the control word, word 2n+1 the buffer pointer
  typedef logic [BD_ADDR_W-1:0]   bd_addr_t;
  typedef logic [BUF_ADDR_W-1:0]  buf_addr_t;
  typedef logic [7:0]             byte_t;
  typedef logic [AXI_ADDR_W-1:0]  axi_addr_t;
  typedef logic [AXI_DATA_W-1:0]  axi_data_t;
  typedef logic [AXI_LEN_W-1:0]   axi_len_t;
  typedef logic [FRAME_LEN_W-1:0] frame_len_t;
  typedef logic [TX_NBYTES_W-1:0] tx_nbytes_t;

  typedef enum logic [3:0] {
    PRE_FILL,
    BD_REQ,
    BD_READ,
    PTR_REQ,
    PTR_READ,
    BURST_ADDR,
    BURST_DATA,
    WAIT_SEND,
    STATUS_WR
  } tx_state_t;

  // Control word bit positions
  localparam int BD_RDY_BIT  = 15;
  localparam int BD_IRQ_BIT  = 14;
  localparam int BD_WRAP_BIT = 13;
  localparam int BD_CRC_BIT  = 11;
  localparam int BD_LEN_LSB  = 16;

  // One byte per beat, so this is also the byte limit of a burst
  localparam int AXI_MAX_BURST = 16;

  localparam int    PREAMBLE_LEN  = 7;
  localparam byte_t PREAMBLE_BYTE = 8'h55;
  localparam byte_t SFD_BYTE      = 8'hD5;
  localparam int    PRE_FRAME_LEN = PREAMBLE_LEN + 1;

endpackage

`default_nettype wire

// File: design/eth_bd_ring.sv
`timescale 1ns/1ps
`default_nettype none

module eth_bd_ring (
  input  logic                  clk_i,
  input  logic                  arst_i,
  input  eth_dma_pkg::bd_word_t bd_i,
  input  logic                  desc_load_i,
  input  logic                  ptr_load_i,
  input  logic                  sent_i,
  input  logic                  advance_i,
  output eth_dma_pkg::bd_idx_t  bd_idx_o,
  output eth_dma_pkg::bd_word_t desc_o,
  output eth_dma_pkg::axi_addr_t buf_ptr_o
);
  import eth_dma_pkg::*;

  bd_idx_t   idx_q;
  bd_idx_t   idx_nxt;
  bd_word_t  desc_q;
  axi_addr_t ptr_q;

  // Wrap bit or last slot of the ring sends us back to descriptor 0
  always_comb begin
    if (desc_q[BD_WRAP_BIT] || (&idx_q)) begin
      idx_nxt = '0;
    end else begin
      idx_nxt = idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      idx_q <= '0;
    end else if (advance_i) begin
      idx_q <= idx_nxt;
    end
  end

  // Control word, updated by fetch and by the status clear
  always_ff @(posedge clk_i) begin
    if (desc_load_i) begin
      desc_q <= bd_i;
    end else if (sent_i) begin
      desc_q[BD_RDY_BIT] <= 1'b0;
    end
  end

  // Buffer pointer in external memory
  always_ff @(posedge clk_i) begin
    if (ptr_load_i) begin
      ptr_q <= bd_i;
    end
  end

  assign bd_idx_o  = idx_q;
  assign desc_o    = desc_q;
  assign buf_ptr_o = ptr_q;

endmodule

`default_nettype wire

// File: design/eth_tx_dma.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_dma (
  input  logic                    clk_i,
  input  logic                    arst_i,
  input  logic                    tx_en_i,
  input  logic                    tx_ready_i,
  input  eth_dma_pkg::bd_word_t   bd_i,
  input  eth_dma_pkg::bd_idx_t    bd_idx_i,
  input  eth_dma_pkg::bd_word_t   desc_i,
  input  eth_dma_pkg::axi_addr_t  buf_ptr_i,
  input  logic                    axi_arready_i,
  input  logic                    axi_rvalid_i,
  input  eth_dma_pkg::axi_data_t  axi_rdata_i,
  input  logic                    axi_rlast_i,
  output logic                    desc_load_o,
  output logic                    ptr_load_o,
  output logic                    sent_o,
  output logic                    advance_o,
  output eth_dma_pkg::bd_addr_t   bd_addr_o,
  output logic                    bd_wen_o,
  output eth_dma_pkg::bd_word_t   bd_o,
  output eth_dma_pkg::axi_addr_t  axi_araddr_o,
  output eth_dma_pkg::axi_len_t   axi_arlen_o,
  output logic                    axi_arvalid_o,
  output logic                    axi_rready_o,
  output logic                    eth_data_wr_wen_o,
  output eth_dma_pkg::buf_addr_t  eth_data_wr_addr_o,
  output eth_dma_pkg::byte_t      eth_data_wr_wdata_o,
  output logic                    crc_en_o,
  output eth_dma_pkg::tx_nbytes_t tx_nbytes_o,
  output logic                    send_o,
  output logic                    tx_irq_o
);
  import eth_dma_pkg::*;

  tx_state_t  state_q;
  tx_state_t  state_d;
  frame_len_t byte_cnt_q;
  frame_len_t byte_cnt_d;

  frame_len_t frame_len;
  frame_len_t bytes_left;
  frame_len_t burst_bytes;
  logic       frame_done;
  axi_addr_t  rd_addr;
  byte_t      rd_byte;

  logic       wr_wen_d;
  logic       wr_wen_q;
  buf_addr_t  wr_addr_d;
  buf_addr_t  wr_addr_q;
  byte_t      wr_data_d;
  byte_t      wr_data_q;

  logic       send_d;
  logic       send_q;
  logic       crc_en_q;
  tx_nbytes_t tx_nbytes_q;

  assign frame_len  = desc_i[BD_LEN_LSB +: FRAME_LEN_W];
  assign bytes_left = frame_len - byte_cnt_q;
  assign frame_done = (bytes_left == '0);

  // Burst covers what is left, capped at 16 beats
  always_comb begin
    if (bytes_left > frame_len_t'(AXI_MAX_BURST)) begin
      burst_bytes = frame_len_t'(AXI_MAX_BURST);
    end else begin
      burst_bytes = bytes_left;
    end
  end

  // Byte address of the next beat and its lane in the read word
  assign rd_addr = buf_ptr_i + axi_addr_t'(byte_cnt_q);
  assign rd_byte = axi_rdata_i[rd_addr[1:0]*8 +: 8];

  // AXI read address and data channels
  assign axi_araddr_o  = rd_addr;
  assign axi_arlen_o   = axi_len_t'(burst_bytes - 1'b1);
  assign axi_arvalid_o = (state_q == BURST_ADDR) && !frame_done;
  assign axi_rready_o  = (state_q == BURST_DATA);

  // Descriptor memory port, pointer word on the odd address
  assign bd_addr_o = {bd_idx_i, (state_q == PTR_REQ)};
  assign bd_wen_o  = (state_q == STATUS_WR);
  assign bd_o      = desc_i;
  assign tx_irq_o  = (state_q == STATUS_WR) && desc_i[BD_IRQ_BIT];

  // Ring block controls
  assign desc_load_o = (state_q == BD_READ);
  assign ptr_load_o  = (state_q == PTR_READ);
  assign sent_o      = (state_q == BURST_ADDR) && frame_done;
  assign advance_o   = (state_q == STATUS_WR);

  always_comb begin
    state_d    = state_q;
    byte_cnt_d = byte_cnt_q;
    send_d     = send_q;
    wr_wen_d   = 1'b0;
    wr_addr_d  = buf_addr_t'(PRE_FRAME_LEN) + buf_addr_t'(byte_cnt_q);
    wr_data_d  = rd_byte;

    case (state_q)
      PRE_FILL: begin
        wr_wen_d   = 1'b1;
        wr_addr_d  = buf_addr_t'(byte_cnt_q);
        byte_cnt_d = byte_cnt_q + 1'b1;
        if (byte_cnt_q == frame_len_t'(PREAMBLE_LEN)) begin
          wr_data_d = SFD_BYTE;
        end else begin
          wr_data_d = PREAMBLE_BYTE;
        end
        if (byte_cnt_q == frame_len_t'(PRE_FRAME_LEN - 1)) begin
          state_d = BD_REQ;
        end
      end

      BD_REQ: begin
        state_d = BD_READ;
      end

      // bd_i is the control word here; poll again if not ours yet
      BD_READ: begin
        if (bd_i[BD_RDY_BIT] && tx_en_i) begin
          state_d = PTR_REQ;
        end else begin
          state_d = BD_REQ;
        end
      end

      PTR_REQ: begin
        state_d = PTR_READ;
      end

      // Hold off until the transmitter buffer is free
      PTR_READ: begin
        byte_cnt_d = '0;
        if (tx_ready_i) begin
          state_d = BURST_ADDR;
        end else begin
          state_d = PTR_REQ;
        end
      end

      BURST_ADDR: begin
        if (frame_done) begin
          send_d  = 1'b1;
          state_d = WAIT_SEND;
        end else if (axi_arready_i) begin
          state_d = BURST_DATA;
        end
      end

      BURST_DATA: begin
        if (axi_rvalid_i) begin
          wr_wen_d   = 1'b1;
          byte_cnt_d = byte_cnt_q + 1'b1;
          if (axi_rlast_i) begin
            state_d = BURST_ADDR;
          end
        end
      end

      // Transmitter drops ready once it has taken the frame
      WAIT_SEND: begin
        if (!tx_ready_i) begin
          send_d  = 1'b0;
          state_d = STATUS_WR;
        end
      end

      STATUS_WR: begin
        state_d = BD_REQ;
      end

      default: begin
        state_d = BD_REQ;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      state_q    <= PRE_FILL;
      byte_cnt_q <= '0;
      send_q     <= 1'b0;
      wr_wen_q   <= 1'b0;
    end else begin
      state_q    <= state_d;
      byte_cnt_q <= byte_cnt_d;
      send_q     <= send_d;
      wr_wen_q   <= wr_wen_d;
    end
  end

  always_ff @(posedge clk_i) begin
    wr_addr_q <= wr_addr_d;
    wr_data_q <= wr_data_d;
  end

  // Transmitter settings, loaded together with the rise of send
  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      crc_en_q    <= 1'b0;
      tx_nbytes_q <= '0;
    end else if (sent_o) begin
      crc_en_q    <= desc_i[BD_CRC_BIT];
      tx_nbytes_q <= tx_nbytes_t'(PRE_FRAME_LEN) + tx_nbytes_t'(frame_len);
    end
  end

  assign eth_data_wr_wen_o   = wr_wen_q;
  assign eth_data_wr_addr_o  = wr_addr_q;
  assign eth_data_wr_wdata_o = wr_data_q;
  assign send_o              = send_q;
  assign crc_en_o            = crc_en_q;
  assign tx_nbytes_o         = tx_nbytes_q;

endmodule

`default_nettype wire

// File: design/eth_dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_dma_top (
  input  logic                    clk_i,
  input  logic                    arst_i,
  input  logic                    tx_en_i,
  input  logic                    tx_ready_i,
  input  eth_dma_pkg::bd_word_t   bd_i,
  output eth_dma_pkg::axi_addr_t  axi_araddr_o,
  output eth_dma_pkg::axi_len_t   axi_arlen_o,
  output logic                    axi_arvalid_o,
  input  logic                    axi_arready_i,
  input  logic                    axi_rvalid_i,
  input  eth_dma_pkg::axi_data_t  axi_rdata_i,
  input  logic                    axi_rlast_i,
  output logic                    axi_rready_o,
  output eth_dma_pkg::bd_addr_t   bd_addr_o,
  output logic                    bd_wen_o,
  output eth_dma_pkg::bd_word_t   bd_o,
  output logic                    eth_data_wr_wen_o,
  output eth_dma_pkg::buf_addr_t  eth_data_wr_addr_o,
  output eth_dma_pkg::byte_t      eth_data_wr_wdata_o,
  output logic                    crc_en_o,
  output eth_dma_pkg::tx_nbytes_t tx_nbytes_o,
  output logic                    send_o,
  output logic                    tx_irq_o
);
  import eth_dma_pkg::*;

  // Ring block to controller
  bd_idx_t   bd_idx;
  bd_word_t  desc;
  axi_addr_t buf_ptr;

  // Controller to ring block
  logic desc_load;
  logic ptr_load;
  logic sent;
  logic advance;

  eth_bd_ring u_bd_ring (
    .clk_i       (clk_i),
    .arst_i      (arst_i),
    .bd_i        (bd_i),
    .desc_load_i (desc_load),
    .ptr_load_i  (ptr_load),
    .sent_i      (sent),
    .advance_i   (advance),
    .bd_idx_o    (bd_idx),
    .desc_o      (desc),
    .buf_ptr_o   (buf_ptr)
  );

  eth_tx_dma u_tx_dma (
    .clk_i               (clk_i),
    .arst_i              (arst_i),
    .tx_en_i             (tx_en_i),
    .tx_ready_i          (tx_ready_i),
    .bd_i                (bd_i),
    .bd_idx_i            (bd_idx),
    .desc_i              (desc),
    .buf_ptr_i           (buf_ptr),
    .axi_arready_i       (axi_arready_i),
    .axi_rvalid_i        (axi_rvalid_i),
    .axi_rdata_i         (axi_rdata_i),
    .axi_rlast_i         (axi_rlast_i),
    .desc_load_o         (desc_load),
    .ptr_load_o          (ptr_load),
    .sent_o              (sent),
    .advance_o           (advance),
    .bd_addr_o           (bd_addr_o),
    .bd_wen_o            (bd_wen_o),
    .bd_o                (bd_o),
    .axi_araddr_o        (axi_araddr_o),
    .axi_arlen_o         (axi_arlen_o),
    .axi_arvalid_o       (axi_arvalid_o),
    .axi_rready_o        (axi_rready_o),
    .eth_data_wr_wen_o   (eth_data_wr_wen_o),
    .eth_data_wr_addr_o  (eth_data_wr_addr_o),
    .eth_data_wr_wdata_o (eth_data_wr_wdata_o),
    .crc_en_o            (crc_en_o),
    .tx_nbytes_o         (tx_nbytes_o),
    .send_o              (send_o),
    .tx_irq_o            (tx_irq_o)
  );

endmodule

`default_nettype wire

// File: test/eth_dma_assert.sv
`timescale 1ns/1ps
`default_nettype none

module eth_dma_assert (
  input logic                   clk_i,
  input logic                   arst_i,
  input logic                   axi_arvalid_o,
  input logic                   axi_arready_i,
  input eth_dma_pkg::axi_addr_t axi_araddr_o,
  input logic                   send_o,
  input logic                   tx_ready_i,
  input logic                   bd_wen_o,
  input eth_dma_pkg::bd_addr_t  bd_addr_o,
  input logic                   eth_data_wr_wen_o,
  input eth_dma_pkg::buf_addr_t eth_data_wr_addr_o
);
  import eth_dma_pkg::*;

  logic [3:0] fill_cnt_q;

  // Counts the preamble writes, saturating once the fill is complete
  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      fill_cnt_q <= '0;
    end else if (eth_data_wr_wen_o && fill_cnt_q < 4'(PRE_FRAME_LEN)) begin
      fill_cnt_q <= fill_cnt_q + 4'd1;
    end
  end

  arvalid_hold: assert property (@(posedge clk_i) disable iff (arst_i)
    axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_araddr_o))
    else $error("arvalid dropped or address changed before arready");

  send_release: assert property (@(posedge clk_i) disable iff (arst_i)
    $fell(send_o) |-> $past(!tx_ready_i))
    else $error("send_o fell while tx_ready_i was high");

  bd_write_even: assert property (@(posedge clk_i) disable iff (arst_i)
    bd_wen_o |-> !bd_addr_o[0])
    else $error("descriptor write to an odd address");

  no_preamble_overwrite: assert property (@(posedge clk_i) disable iff (arst_i)
    eth_data_wr_wen_o && fill_cnt_q == 4'(PRE_FRAME_LEN) |->
      eth_data_wr_addr_o >= buf_addr_t'(PRE_FRAME_LEN))
    else $error("frame-buffer write into the preamble area");

endmodule

bind eth_dma_top eth_dma_assert u_dma_assert (.*);

`default_nettype wire

// File: test/tb_eth_dma.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eth_dma;
  import eth_dma_pkg::*;

  logic       clk_i = 1'b0;
  logic       arst_i;
  logic       tx_en_i;
  logic       tx_ready_i;
  bd_word_t   bd_i;
  axi_addr_t  axi_araddr_o;
  axi_len_t   axi_arlen_o;
  logic       axi_arvalid_o;
  logic       axi_arready_i;
  logic       axi_rvalid_i;
  axi_data_t  axi_rdata_i;
  logic       axi_rlast_i;
  logic       axi_rready_o;
  bd_addr_t   bd_addr_o;
  logic       bd_wen_o;
  bd_word_t   bd_o;
  logic       eth_data_wr_wen_o;
  buf_addr_t  eth_data_wr_addr_o;
  byte_t      eth_data_wr_wdata_o;
  logic       crc_en_o;
  tx_nbytes_t tx_nbytes_o;
  logic       send_o;
  logic       tx_irq_o;

  // Golden word 0 is the count, three words per descriptor from word 1
  // Memory words from byte address 0x100 start at word 16
  logic [31:0] golden [0:31];
  bd_word_t    bd_mem [0:255];
  bd_addr_t    bd_rd_addr = '0;
  byte_t       fb [0:2047];
  integer      seed = 32'h6101;
  integer      value_errs = 0;
  integer      proto_errs = 0;
  integer      cycles = 0;
  integer      cycle_limit = 100000;
  logic        burst_busy = 1'b0;
  axi_addr_t   beat_addr;
  integer      beats_left;
  axi_addr_t   next_addr;

  eth_dma_top u_eth_dma_top (.*);

  always #2 clk_i = ~clk_i;

  function automatic byte_t mem_byte(input axi_addr_t addr);
    logic [31:0] w;
    w = golden[16 + (addr - 32'h100) / 4];
    return w[addr[1:0]*8 +: 8];
  endfunction

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %02h expected %02h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_word(input string name, input bd_word_t got, input bd_word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %08h expected %08h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_axi_addr(input string name, input axi_addr_t got,
                                input axi_addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %08h expected %08h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_nbytes(input string name, input tx_nbytes_t got,
                              input tx_nbytes_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_bd_addr(input string name, input bd_addr_t got, input bd_addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
      value_errs++;
    end
  endtask

  // Descriptor memory, frame buffer and irq watch
  always @(negedge clk_i) begin
    if (bd_wen_o) begin
      bd_mem[bd_addr_o] = bd_o;
    end
    // Read data follows the address of the previous cycle
    bd_i <= bd_mem[bd_rd_addr];
    bd_rd_addr = bd_addr_o;
    if (eth_data_wr_wen_o) begin
      fb[eth_data_wr_addr_o] = eth_data_wr_wdata_o;
    end
    if (tx_irq_o && !bd_wen_o) begin
      $display("Interrupt pulsed outside a status write at t=%0t", $time);
      proto_errs++;
    end
  end

  // AXI read slave with random stalls; decisions apply at the next rising edge
  always @(negedge clk_i) begin
    if (!burst_busy) begin
      axi_rvalid_i  <= 1'b0;
      axi_rlast_i   <= 1'b0;
      axi_arready_i <= 1'b0;
      if (axi_arvalid_o && ($random(seed) & 1)) begin
        axi_arready_i <= 1'b1;
        if (axi_arlen_o > axi_len_t'(AXI_MAX_BURST - 1)) begin
          $display("Burst of %0d beats exceeds the limit", axi_arlen_o + 1);
          proto_errs++;
        end
        check_axi_addr("axi_araddr_o", axi_araddr_o, next_addr);
        burst_busy = 1'b1;
        beat_addr  = axi_araddr_o;
        beats_left = axi_arlen_o + 1;
        next_addr  = axi_araddr_o + axi_arlen_o + 1;
      end
    end else begin
      axi_arready_i <= 1'b0;
      axi_rvalid_i  <= 1'b0;
      axi_rlast_i   <= 1'b0;
      if (axi_rready_o && ($random(seed) % 3 != 0)) begin
        axi_rvalid_i <= 1'b1;
        axi_rdata_i  <= golden[16 + (beat_addr - 32'h100) / 4];
        axi_rlast_i  <= (beats_left == 1);
        beat_addr  = beat_addr + 1;
        beats_left = beats_left - 1;
        if (beats_left == 0) begin
          burst_busy = 1'b0;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: no progress after %0d cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    integer   nd;
    integer   total;
    integer   n;
    integer   k;
    bd_word_t ctrl;
    axi_addr_t ptr;
    integer   len;
    arst_i = 1'b1;
    tx_en_i = 1'b0;
    tx_ready_i = 1'b1;
    axi_arready_i = 1'b0;
    axi_rvalid_i = 1'b0;
    axi_rdata_i = '0;
    axi_rlast_i = 1'b0;
    bd_i = '0;
    $readmemh("test/eth_dma_golden.hex", golden);
    nd = golden[0];
    total = 0;
    for (n = 0; n < 256; n++) begin
      bd_mem[n] = '0;
    end
    for (n = 0; n < nd; n++) begin
      bd_mem[2*n]   = golden[1 + 3*n];
      bd_mem[2*n+1] = golden[2 + 3*n];
      total = total + golden[1 + 3*n][31:16];
    end
    // Worst case about 12 cycles per byte under stalls, plus per-frame overhead
    cycle_limit = total * 12 + nd * 60 + 200;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_i = 1'b0;
    // Ready descriptor must not start a fetch while transmit is disabled
    repeat (20) begin
      @(negedge clk_i);
      check_flag("axi_arvalid_o", axi_arvalid_o, 1'b0);
    end
    for (k = 0; k < PRE_FRAME_LEN; k++) begin
      check_byte("preamble", fb[k], (k == PREAMBLE_LEN) ? SFD_BYTE : PREAMBLE_BYTE);
    end
    for (n = 0; n < nd; n++) begin
      ctrl = golden[1 + 3*n];
      ptr  = golden[2 + 3*n];
      len  = ctrl[31:16];
      for (k = PRE_FRAME_LEN; k < 2048; k++) begin
        fb[k] = 8'hEE;
      end
      next_addr = ptr;
      tx_en_i = 1'b1;
      while (!send_o) @(negedge clk_i);
      check_nbytes("tx_nbytes_o", tx_nbytes_o, tx_nbytes_t'(PRE_FRAME_LEN + len));
      check_flag("crc_en_o", crc_en_o, ctrl[BD_CRC_BIT]);
      for (k = 0; k < len; k++) begin
        check_byte("frame byte", fb[PRE_FRAME_LEN + k], mem_byte(ptr + k));
      end
      // Transmitter busy for a while before it takes the frame
      repeat ($unsigned($random(seed)) % 4) @(negedge clk_i);
      tx_ready_i = 1'b0;
      while (!bd_wen_o) @(negedge clk_i);
      check_bd_addr("bd_addr_o", bd_addr_o, bd_addr_t'(2*n));
      check_word("bd_o", bd_o, golden[3 + 3*n]);
      check_flag("tx_irq_o", tx_irq_o, ctrl[BD_IRQ_BIT]);
      @(negedge clk_i);
      tx_ready_i = 1'b1;
    end
    // After the wrap the ring polls descriptor 0, now owned by software
    repeat (12) begin
      @(negedge clk_i);
      check_flag("axi_arvalid_o", axi_arvalid_o, 1'b0);
      if (!bd_addr_o[0]) begin
        check_bd_addr("bd_addr_o", bd_addr_o, '0);
      end
    end
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/eth_dma_golden.hex
// [0] descriptor count; per descriptor: control word, buffer pointer, expected status
// @10 onward: external memory words from byte address 0x100, little endian
@0
00000002
0005C800
00000102
00054800
0014A000
00000111
00142000
@10
13A7C4F1
5B2E9D08
71C36A42
0F9E8B24
D3158C6A
47B2F019
9A6C3E85
2D71B4C8
E5096F3A
8C43D217

// File: src.f
design/eth_dma_pkg.sv
design/eth_bd_ring.sv
design/eth_tx_dma.sv
design/eth_dma_top.sv
test/eth_dma_assert.sv
test/tb_eth_dma.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_eth_dma
FILELIST  := src.f
LOG       := sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
